// File: common/dma_rd_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read request path definitions shared by counters, mux and testbench
// Addresses and lengths are in 64-byte blocks only
// Tag is zero pad, channel number, then per-channel sequence number
// Sequence field wraps modulo 8 with no recycling of outstanding tags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package dma_rd_pkg;

   localparam int NUM_CHANNELS = 4;                          // Request channels
   localparam int CH_IDX_W     = $clog2(NUM_CHANNELS);       // Channel number width
   localparam int BLK_ADDR_W   = 55;                         // 64-byte block address
   localparam int BLK_COUNT_W  = 13;                         // Job length in blocks
   localparam int TAG_LOW_W    = 3;                          // Per-channel sequence
   localparam int TAG_W        = 8;                          // Full request tag
   localparam int TAG_PAD_W    = TAG_W - CH_IDX_W - TAG_LOW_W; // Zero pad on top

   typedef logic [BLK_ADDR_W-1:0]   blk_addr_t;
   typedef logic [BLK_COUNT_W-1:0]  blk_count_t;
   typedef logic [CH_IDX_W-1:0]     ch_idx_t;
   typedef logic [TAG_LOW_W-1:0]    tag_low_t;
   typedef logic [TAG_W-1:0]        req_tag_t;
   typedef logic [NUM_CHANNELS-1:0] ch_mask_t;                // One bit per channel

   // Mux visit of one channel
   typedef enum logic [1:0]
   {
      SCAN,                                                  // Test channel for work
      LOAD,                                                  // Capture addr and tag
      STEP,                                                  // Consume block in counter
      OFFER                                                  // Hold request until ready
   } mux_state_t;

   // Tag as seen on the request port
   function automatic req_tag_t make_tag(input ch_idx_t ch, input tag_low_t seq);
      req_tag_t tag;
      tag = {{TAG_PAD_W{1'b0}}, ch, seq};                    // Pad, channel, sequence
      return tag;
   endfunction

endpackage

// File: common/apb_regs_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB register map of the read request block
// Channel n job registers start at n * CH_STRIDE, STATUS is global
// Only word offsets listed here decode, everything else is unmapped
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package apb_regs_pkg;

   localparam int APB_ADDR_W = 12;
   localparam int APB_DATA_W = 32;

   typedef logic [APB_ADDR_W-1:0] apb_addr_t;
   typedef logic [APB_DATA_W-1:0] apb_data_t;

   localparam apb_addr_t CH_STRIDE  = 12'h020;               // Bytes per channel window
   localparam int        CH_SHIFT   = $clog2(CH_STRIDE);     // Offset bits in window
   localparam apb_addr_t STATUS_OFS = 12'h100;               // Global status word

   typedef logic [CH_SHIFT-1:0] reg_ofs_t;

   localparam reg_ofs_t OFS_ADDR_LO   = 5'h00;               // Block address 31:0
   localparam reg_ofs_t OFS_ADDR_HI   = 5'h04;               // Block address 54:32
   localparam reg_ofs_t OFS_COUNT_IRQ = 5'h08;               // Length and irq enable
   localparam reg_ofs_t OFS_START     = 5'h0C;               // Write to launch job

   localparam int IRQ_EN_BIT = 31;                           // In COUNT_IRQ
   localparam int BUSY_LSB   = 0;                            // In STATUS
   localparam int IRQ_LSB    = 8;                            // In STATUS, write 1 clears

   typedef enum logic [2:0]
   {
      SEL_NONE, ADDR_LO, ADDR_HI, COUNT_IRQ, START, STATUS
   } reg_sel_t;

endpackage

// File: common/rd_req_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One channel's pending request between its counter and the mux
// valid lags the count by one cycle, load_busy covers that window
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

interface rd_req_if;
   import dma_rd_pkg::*;

   logic      valid;                                         // Count is nonzero
   blk_addr_t addr;                                          // Current block address
   logic      step;                                          // Consume current block
   logic      load_busy;                                     // Job load in progress

   modport producer
   (
      output valid,
      output addr,
      output load_busy,
      input  step
   );

   modport consumer
   (
      input  valid,
      input  addr,
      input  load_busy,
      output step
   );

endinterface

// File: hw/apb_channel_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB slave with per-channel job registers, busy and sticky irq bits
// Zero wait states, o_pready is tied high
// START on a busy channel is dropped and flagged with o_pslverr
// START with a zero length is dropped without error
// Irq enable is sampled at START, later writes affect the next job only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module apb_channel_regs
(
   input  logic                                i_clock,
   input  logic                                i_reset,
   input  logic                                i_psel,
   input  logic                                i_penable,
   input  logic                                i_pwrite,
   input  logic [apb_regs_pkg::APB_ADDR_W-1:0] i_paddr,
   input  logic [apb_regs_pkg::APB_DATA_W-1:0] i_pwdata,
   output logic [apb_regs_pkg::APB_DATA_W-1:0] o_prdata,
   output logic                                o_pready,
   output logic                                o_pslverr,
   input  dma_rd_pkg::ch_mask_t                i_done,
   output dma_rd_pkg::ch_mask_t                o_start,
   output dma_rd_pkg::blk_addr_t               o_addr [dma_rd_pkg::NUM_CHANNELS],
   output dma_rd_pkg::blk_count_t              o_count [dma_rd_pkg::NUM_CHANNELS],
   output logic                                o_irq
);
   import dma_rd_pkg::*;
   import apb_regs_pkg::*;

   localparam int ADDR_HI_W = BLK_ADDR_W - APB_DATA_W;      // Bits held in ADDR_HI

   logic     access;                                         // APB access phase
   logic     wr_access;
   reg_sel_t sel;
   ch_idx_t  ch;
   logic     start_ok;
   ch_mask_t busy_q;
   ch_mask_t irq_q;                                          // Sticky, write 1 clears
   ch_mask_t irq_en_q;                                       // As programmed
   ch_mask_t irq_arm_q;                                      // Captured at START

   function automatic reg_sel_t decode(input apb_addr_t paddr);
      reg_sel_t kind;
      kind = SEL_NONE;
      if (paddr == STATUS_OFS)
         kind = STATUS;
      else if (paddr < CH_STRIDE * NUM_CHANNELS)             // Inside channel windows
      begin
         case (paddr[CH_SHIFT-1:0])
            OFS_ADDR_LO:   kind = ADDR_LO;
            OFS_ADDR_HI:   kind = ADDR_HI;
            OFS_COUNT_IRQ: kind = COUNT_IRQ;
            OFS_START:     kind = START;
            default:       kind = SEL_NONE;                  // Hole in the window
         endcase
      end
      return kind;
   endfunction

   assign access    = i_psel & i_penable;
   assign wr_access = access & i_pwrite;
   assign sel       = decode(i_paddr);
   assign ch        = i_paddr[CH_SHIFT +: CH_IDX_W];          // Window number
   assign start_ok  = wr_access && (sel == START) && !busy_q[ch] && (o_count[ch] != '0);

   assign o_pready  = 1'b1;                                  // Single cycle access
   assign o_pslverr = access && ((sel == SEL_NONE) ||
                                 (i_pwrite && (sel == START) && busy_q[ch]));
   assign o_irq     = |irq_q;

   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         o_start   <= '0;
         busy_q    <= '0;
         irq_q     <= '0;
         irq_en_q  <= '0;
         irq_arm_q <= '0;
         for (int c = 0; c < NUM_CHANNELS; c++)
            o_count[c] <= '0;
      end
      else
      begin
         o_start <= '0;                                      // Pulse for one cycle
         busy_q  <= busy_q & ~i_done;                        // Job finished issuing
         irq_q   <= irq_q | (i_done & irq_arm_q);
         if (wr_access)
         begin
            case (sel)
               COUNT_IRQ:
               begin
                  o_count[ch]  <= i_pwdata[BLK_COUNT_W-1:0];
                  irq_en_q[ch] <= i_pwdata[IRQ_EN_BIT];
               end
               START:
               begin
                  if (start_ok)
                  begin
                     o_start[ch]   <= 1'b1;                  // Counter loads next cycle
                     busy_q[ch]    <= 1'b1;
                     irq_arm_q[ch] <= irq_en_q[ch];
                  end
               end
               STATUS:                                       // New done wins over clear
                  irq_q <= (irq_q & ~i_pwdata[IRQ_LSB +: NUM_CHANNELS]) | (i_done & irq_arm_q);
               default:
               begin
               end
            endcase
         end
      end
   end

   // Job address words
   always_ff @(posedge i_clock)
   begin
      if (wr_access && (sel == ADDR_LO))
         o_addr[ch][APB_DATA_W-1:0] <= i_pwdata;
      else if (wr_access && (sel == ADDR_HI))
         o_addr[ch][BLK_ADDR_W-1:APB_DATA_W] <= i_pwdata[ADDR_HI_W-1:0];
   end

   always_comb
   begin
      o_prdata = '0;                                         // Idle bus reads zero
      if (access && !i_pwrite)
      begin
         case (sel)
            ADDR_LO:   o_prdata = o_addr[ch][APB_DATA_W-1:0];
            ADDR_HI:   o_prdata[ADDR_HI_W-1:0] = o_addr[ch][BLK_ADDR_W-1:APB_DATA_W];
            COUNT_IRQ:
            begin
               o_prdata[BLK_COUNT_W-1:0] = o_count[ch];
               o_prdata[IRQ_EN_BIT]      = irq_en_q[ch];
            end
            STATUS:
            begin
               o_prdata[BUSY_LSB +: NUM_CHANNELS] = busy_q;
               o_prdata[IRQ_LSB +: NUM_CHANNELS]  = irq_q;
            end
            default:   o_prdata = '0;                        // START reads as zero
         endcase
      end
   end

endmodule

// File: hw/request_count.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Per-channel job counter feeding the round-robin mux
// A new start is only expected once the previous job has drained
// valid follows the count one cycle late
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module request_count
(
   input  logic                   i_clock,
   input  logic                   i_reset,
   input  logic                   i_start,
   input  dma_rd_pkg::blk_addr_t  i_addr,
   input  dma_rd_pkg::blk_count_t i_count,
   rd_req_if.producer             o_rd_req,
   output logic                   o_done
);
   import dma_rd_pkg::*;

   blk_addr_t  addr_q;
   blk_count_t count_q;                                      // Blocks left to issue
   logic       valid_q;
   logic       load_q;                                       // Cycle after the load

   // Address steps once per consumed block
   always_ff @(posedge i_clock)
   begin
      if (i_start)
         addr_q <= i_addr;
      else if (o_rd_req.step)
         addr_q <= addr_q + 1'b1;                            // Next 64-byte block
   end

   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         count_q <= '0;
         valid_q <= 1'b0;
         load_q  <= 1'b0;
      end
      else
      begin
         load_q <= i_start;
         if (i_start)
            count_q <= i_count;
         else if (o_rd_req.step && (count_q != '0))
            count_q <= count_q - 1'b1;
         valid_q <= (count_q != '0);                         // Lags count by one
      end
   end

   assign o_rd_req.valid     = valid_q;
   assign o_rd_req.addr      = addr_q;
   assign o_rd_req.load_busy = i_start | load_q;             // valid not yet current
   assign o_done             = o_rd_req.step && !i_start && (count_q == blk_count_t'(1));

endmodule

// File: hw/rr_mux.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin merge of the channel counters onto one request port
// Each visit is SCAN, LOAD, STEP, OFFER, so four cycles per request minimum
// An idle channel costs one SCAN cycle
// Back-pressure holds OFFER and stalls every channel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module rr_mux
(
   input  logic                  i_clock,
   input  logic                  i_reset,
   rd_req_if.consumer            i_rd_req [dma_rd_pkg::NUM_CHANNELS],
   input  logic                  i_req_ready,
   output logic                  o_req_valid,
   output dma_rd_pkg::blk_addr_t o_req_addr,
   output dma_rd_pkg::req_tag_t  o_req_tag
);
   import dma_rd_pkg::*;

   mux_state_t state_q;
   ch_idx_t    ch_q;                                         // Channel being visited
   tag_low_t   seq_q [NUM_CHANNELS];                         // Next sequence per channel
   ch_mask_t   pending;
   blk_addr_t  ch_addr [NUM_CHANNELS];
   logic       transfer;

   // Flatten the interface array for indexing by ch_q
   genvar i;
   generate
      for (i = 0; i < NUM_CHANNELS; i++)
      begin : g_ch
         assign pending[i]       = i_rd_req[i].valid & ~i_rd_req[i].load_busy;
         assign ch_addr[i]       = i_rd_req[i].addr;
         assign i_rd_req[i].step = (state_q == STEP) && (ch_q == ch_idx_t'(i));
      end
   endgenerate

   assign o_req_valid = (state_q == OFFER);
   assign transfer    = o_req_valid & i_req_ready;

   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         state_q <= SCAN;
         ch_q    <= '0;
         for (int c = 0; c < NUM_CHANNELS; c++)
            seq_q[c] <= '0;
      end
      else
      begin
         case (state_q)
            SCAN:
            begin
               if (pending[ch_q])
                  state_q <= LOAD;
               else
                  ch_q <= ch_q + 1'b1;                       // Skip idle channel
            end
            LOAD:
               state_q <= STEP;
            STEP:
               state_q <= OFFER;                             // Counter steps this edge
            OFFER:
            begin
               if (transfer)
               begin
                  seq_q[ch_q] <= seq_q[ch_q] + 1'b1;         // Wraps modulo 8
                  ch_q        <= ch_q + 1'b1;                // Move on after a transfer
                  state_q     <= SCAN;
               end
            end
            default:
               state_q <= SCAN;
         endcase
      end
   end

   // Request payload, stable through OFFER
   always_ff @(posedge i_clock)
   begin
      if (state_q == LOAD)
      begin
         o_req_addr <= ch_addr[ch_q];
         o_req_tag  <= make_tag(ch_q, seq_q[ch_q]);
      end
   end

endmodule

// File: hw/dma_read_req_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read request side of the PCIe to FIFO bridge
// Jobs are programmed over APB and issued as single-block read requests
// No completion handling, tags are not recycled
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module dma_read_req_top
(
   input  logic                                i_clock,
   input  logic                                i_reset,
   input  logic                                i_psel,
   input  logic                                i_penable,
   input  logic                                i_pwrite,
   input  logic [apb_regs_pkg::APB_ADDR_W-1:0] i_paddr,
   input  logic [apb_regs_pkg::APB_DATA_W-1:0] i_pwdata,
   output logic [apb_regs_pkg::APB_DATA_W-1:0] o_prdata,
   output logic                                o_pready,
   output logic                                o_pslverr,
   output logic                                o_irq,
   input  logic                                i_req_ready,
   output logic                                o_req_valid,
   output dma_rd_pkg::blk_addr_t               o_req_addr,
   output dma_rd_pkg::req_tag_t                o_req_tag
);
   import dma_rd_pkg::*;

   ch_mask_t   start;                                        // Job load pulses
   ch_mask_t   done;                                         // Last block consumed
   blk_addr_t  job_addr [NUM_CHANNELS];
   blk_count_t job_count [NUM_CHANNELS];

   rd_req_if rd_req [NUM_CHANNELS] ();

   apb_channel_regs u_regs
   (
      .i_clock   (i_clock),
      .i_reset   (i_reset),
      .i_psel    (i_psel),
      .i_penable (i_penable),
      .i_pwrite  (i_pwrite),
      .i_paddr   (i_paddr),
      .i_pwdata  (i_pwdata),
      .o_prdata  (o_prdata),
      .o_pready  (o_pready),
      .o_pslverr (o_pslverr),
      .i_done    (done),
      .o_start   (start),
      .o_addr    (job_addr),
      .o_count   (job_count),
      .o_irq     (o_irq)
   );

   genvar i;
   generate
      for (i = 0; i < NUM_CHANNELS; i++)
      begin : g_count
         request_count u_count
         (
            .i_clock  (i_clock),
            .i_reset  (i_reset),
            .i_start  (start[i]),
            .i_addr   (job_addr[i]),
            .i_count  (job_count[i]),
            .o_rd_req (rd_req[i]),
            .o_done   (done[i])
         );
      end
   endgenerate

   rr_mux u_mux
   (
      .i_clock     (i_clock),
      .i_reset     (i_reset),
      .i_rd_req    (rd_req),
      .i_req_ready (i_req_ready),
      .o_req_valid (o_req_valid),
      .o_req_addr  (o_req_addr),
      .o_req_tag   (o_req_tag)
   );

endmodule

// File: verif/tb_dma_read_req.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the read request block, jobs come from a batched table
// Each batch is programmed with ready low, then drained with random ready
// The first row of a batch must have two or more blocks
// Round-robin order is predicted from the blocks left per channel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_dma_read_req;
   import dma_rd_pkg::*;
   import apb_regs_pkg::*;

   localparam int NUM_ROWS     = 8;
   localparam int NUM_BATCHES  = 3;
   localparam int RESET_CYCLES = 8;
   localparam int PROG_CYCLES  = 24;                         // Six APB accesses per row
   localparam int CHECK_CYCLES = 60;                         // Status traffic per batch
   localparam int BLOCK_CYCLES = 40;

   typedef struct packed
   {
      logic [1:0] batch;
      ch_idx_t    ch;
      blk_addr_t  addr;
      blk_count_t count;
      logic       irq;
   } job_row_t;

   job_row_t jobs [NUM_ROWS] = '{
      '{2'd0, 2'd0, 55'h00_0000_0001_0000, 13'd5, 1'b1},
      '{2'd0, 2'd2, 55'h00_0000_FFFF_FFFE, 13'd4, 1'b0},     // Crosses ADDR_LO
      '{2'd0, 2'd3, 55'h40_0000_0000_0000, 13'd3, 1'b1},
      '{2'd0, 2'd1, 55'h00_0000_0000_0123, 13'd6, 1'b0},
      '{2'd1, 2'd1, 55'h7F_FFFF_FFFF_FFFD, 13'd5, 1'b1},     // Wraps at top, seq wraps
      '{2'd2, 2'd2, 55'h12_3456_789A_BCDE, 13'd2, 1'b0},
      '{2'd2, 2'd0, 55'h00_0000_0000_0040, 13'd7, 1'b0},
      '{2'd2, 2'd3, 55'h00_0000_0000_0800, 13'd1, 1'b0}
   };

   logic      clock;
   logic      reset;
   logic      i_psel;
   logic      i_penable;
   logic      i_pwrite;
   apb_addr_t i_paddr;
   apb_data_t i_pwdata;
   apb_data_t o_prdata;
   logic      o_pready;
   logic      o_pslverr;
   logic      o_irq;
   logic      i_req_ready;
   logic      o_req_valid;
   blk_addr_t o_req_addr;
   req_tag_t  o_req_tag;

   blk_addr_t exp_q [NUM_CHANNELS][$];                       // Addresses still owed
   tag_low_t  seq [NUM_CHANNELS];                            // Never reset between jobs
   int        total_left;
   int        next_ch;                                       // Predicted source channel
   logic      ready_en;
   logic      held;                                          // Stalled at last negedge
   blk_addr_t held_addr;
   req_tag_t  held_tag;
   int        error_count;

   dma_read_req_top UUT
   (
      .i_clock     (clock),
      .i_reset     (reset),
      .i_psel      (i_psel),
      .i_penable   (i_penable),
      .i_pwrite    (i_pwrite),
      .i_paddr     (i_paddr),
      .i_pwdata    (i_pwdata),
      .o_prdata    (o_prdata),
      .o_pready    (o_pready),
      .o_pslverr   (o_pslverr),
      .o_irq       (o_irq),
      .i_req_ready (i_req_ready),
      .o_req_valid (o_req_valid),
      .o_req_addr  (o_req_addr),
      .o_req_tag   (o_req_tag)
   );

   always #4 clock = ~clock;                                 // 8 ns period

   task automatic stop_on_error();
      $display("Simulation failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic report_error(input string msg);
      error_count++;
      $display("ERROR at %0t: %s", $time, msg);
      stop_on_error();
   endtask

   task automatic check_addr(input string name, input blk_addr_t act, input blk_addr_t exp);
      if (act !== exp)
      begin
         error_count++;
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, act, exp);
         stop_on_error();
      end
   endtask

   task automatic check_tag(input string name, input req_tag_t act, input req_tag_t exp);
      if (act !== exp)
      begin
         error_count++;
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, act, exp);
         stop_on_error();
      end
   endtask

   task automatic check_reg(input string name, input apb_data_t act, input apb_data_t exp);
      if (act !== exp)
      begin
         error_count++;
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, act, exp);
         stop_on_error();
      end
   endtask

   task automatic check_flag(input string name, input logic act, input logic exp);
      if (act !== exp)
      begin
         error_count++;
         $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, act, exp);
         stop_on_error();
      end
   endtask

   function automatic apb_addr_t reg_addr(input ch_idx_t ch, input reg_ofs_t ofs);
      return apb_addr_t'(ch) * CH_STRIDE + apb_addr_t'(ofs);
   endfunction

   // First channel after last, cyclically, that still owes a block
   function automatic int next_pending(input int last);
      int c;
      for (int k = 1; k <= NUM_CHANNELS; k++)
      begin
         c = (last + k) % NUM_CHANNELS;
         if (exp_q[c].size() > 0)
            return c;
      end
      return -1;
   endfunction

   task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
      @(posedge clock);
      i_psel    <= 1'b1;                                     // Setup phase
      i_penable <= 1'b0;
      i_pwrite  <= 1'b1;
      i_paddr   <= addr;
      i_pwdata  <= data;
      @(posedge clock);
      i_penable <= 1'b1;                                     // Access phase
      @(negedge clock);
      err = o_pslverr;
      check_flag("o_pready", o_pready, 1'b1);                // No wait states
      @(posedge clock);
      i_psel    <= 1'b0;
      i_penable <= 1'b0;
      i_pwrite  <= 1'b0;
   endtask

   task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
      @(posedge clock);
      i_psel    <= 1'b1;
      i_penable <= 1'b0;
      i_pwrite  <= 1'b0;
      i_paddr   <= addr;
      @(posedge clock);
      i_penable <= 1'b1;
      @(negedge clock);
      data = o_prdata;                                       // Mid access phase
      err  = o_pslverr;
      check_flag("o_pready", o_pready, 1'b1);
      @(posedge clock);
      i_psel    <= 1'b0;
      i_penable <= 1'b0;
   endtask

   task automatic score_request();
      req_tag_t  exp_tag;
      blk_addr_t exp_addr;
      int        ch;
      ch = next_ch;
      if ((ch < 0) || (exp_q[ch].size() == 0))
         report_error("request issued with no block outstanding");
      else
      begin
         exp_tag = '0;
         exp_tag[TAG_LOW_W +: CH_IDX_W] = ch_idx_t'(ch);     // Channel above sequence
         exp_tag[TAG_LOW_W-1:0]         = seq[ch];
         exp_addr = exp_q[ch].pop_front();
         check_tag("o_req_tag", o_req_tag, exp_tag);
         check_addr("o_req_addr", o_req_addr, exp_addr);
         seq[ch] = seq[ch] + 1'b1;                           // Modulo 8
         total_left--;
         next_ch = next_pending(ch);
      end
   endtask

   // Transfer monitor, inputs and outputs only move on rising edges
   always @(negedge clock)
   begin
      if (!reset)
      begin
         if (held)
         begin
            check_flag("o_req_valid under stall", o_req_valid, 1'b1);
            check_addr("o_req_addr under stall", o_req_addr, held_addr);
            check_tag("o_req_tag under stall", o_req_tag, held_tag);
         end
         held      = o_req_valid && !i_req_ready;
         held_addr = o_req_addr;
         held_tag  = o_req_tag;
         if (o_req_valid && i_req_ready)
            score_request();                                 // Transfers on next edge
      end
   end

   always @(posedge clock)
      i_req_ready <= ready_en && ($urandom_range(99) < 60);  // Random back-pressure

   task automatic program_job(input int r);
      blk_addr_t a;
      apb_data_t rdata;
      apb_data_t cnt_word;
      logic      err;
      a = jobs[r].addr;
      for (int k = 0; k < int'(jobs[r].count); k++)
      begin
         exp_q[jobs[r].ch].push_back(a);
         a = a + 1'b1;
         total_left++;
      end
      cnt_word = '0;
      cnt_word[BLK_COUNT_W-1:0] = jobs[r].count;
      cnt_word[IRQ_EN_BIT]      = jobs[r].irq;
      apb_write(reg_addr(jobs[r].ch, OFS_ADDR_LO), jobs[r].addr[APB_DATA_W-1:0], err);
      check_flag("o_pslverr ADDR_LO", err, 1'b0);
      apb_write(reg_addr(jobs[r].ch, OFS_ADDR_HI),
                apb_data_t'(jobs[r].addr[BLK_ADDR_W-1:APB_DATA_W]), err);
      check_flag("o_pslverr ADDR_HI", err, 1'b0);
      apb_write(reg_addr(jobs[r].ch, OFS_COUNT_IRQ), cnt_word, err);
      check_flag("o_pslverr COUNT_IRQ", err, 1'b0);
      apb_read(reg_addr(jobs[r].ch, OFS_COUNT_IRQ), rdata, err);
      check_reg("COUNT_IRQ readback", rdata, cnt_word);
      apb_read(reg_addr(jobs[r].ch, OFS_ADDR_HI), rdata, err);
      check_reg("ADDR_HI readback", rdata, apb_data_t'(jobs[r].addr[BLK_ADDR_W-1:APB_DATA_W]));
      apb_write(reg_addr(jobs[r].ch, OFS_START), 32'h1, err);
      check_flag("o_pslverr START", err, 1'b0);
   endtask

   task automatic run_batch(input int b);
      ch_mask_t  busy_mask;
      ch_mask_t  irq_mask;
      int        first;
      apb_data_t rdata;
      logic      err;
      busy_mask = '0;
      irq_mask  = '0;
      first     = -1;
      for (int r = 0; r < NUM_ROWS; r++)
      begin
         if (int'(jobs[r].batch) == b)
         begin
            if (first < 0)
            begin
               first   = r;
               next_ch = int'(jobs[r].ch);                   // Mux parks on this one
            end
            program_job(r);
            busy_mask[jobs[r].ch] = 1'b1;
            irq_mask[jobs[r].ch]  = jobs[r].irq;
         end
      end
      apb_read(STATUS_OFS, rdata, err);
      check_reg("STATUS busy", rdata, apb_data_t'(busy_mask));
      apb_write(reg_addr(jobs[first].ch, OFS_START), 32'h1, err);
      check_flag("o_pslverr START on busy channel", err, 1'b1);
      ready_en <= 1'b1;
      while (total_left != 0)
         @(posedge clock);
      ready_en <= 1'b0;
      apb_read(STATUS_OFS, rdata, err);
      check_reg("STATUS done", rdata, apb_data_t'(irq_mask) << IRQ_LSB);
      @(negedge clock);
      check_flag("o_irq", o_irq, |irq_mask);
      apb_write(STATUS_OFS, apb_data_t'(irq_mask) << IRQ_LSB, err); // W1C
      check_flag("o_pslverr STATUS write", err, 1'b0);
      apb_read(STATUS_OFS, rdata, err);
      check_reg("STATUS cleared", rdata, '0);
      @(negedge clock);
      check_flag("o_irq cleared", o_irq, 1'b0);
      check_flag("o_req_valid idle", o_req_valid, 1'b0);
   endtask

   initial
   begin
      int        limit;
      limit = RESET_CYCLES + NUM_BATCHES * CHECK_CYCLES + NUM_ROWS * PROG_CYCLES;
      for (int r = 0; r < NUM_ROWS; r++)
         limit += int'(jobs[r].count) * BLOCK_CYCLES;
      repeat (limit) @(posedge clock);
      $display("ERROR at %0t: timeout waiting for requests", $time);
      $display("Simulation failed");
      $fatal(1, "watchdog expired");
   end

   initial
   begin
      apb_data_t rdata;
      logic      err;
      clock       = 1'b0;
      reset       = 1'b1;
      i_psel      = 1'b0;
      i_penable   = 1'b0;
      i_pwrite    = 1'b0;
      i_paddr     = '0;
      i_pwdata    = '0;
      i_req_ready = 1'b0;
      ready_en    = 1'b0;
      total_left  = 0;
      next_ch     = -1;
      held        = 1'b0;
      error_count = 0;
      for (int c = 0; c < NUM_CHANNELS; c++)
         seq[c] = '0;
      void'($urandom(56));
      repeat (RESET_CYCLES) @(posedge clock);
      reset <= 1'b0;
      @(negedge clock);
      check_flag("o_req_valid after reset", o_req_valid, 1'b0);
      check_flag("o_irq after reset", o_irq, 1'b0);
      check_reg("o_prdata idle", o_prdata, '0);
      apb_read(STATUS_OFS, rdata, err);
      check_reg("STATUS after reset", rdata, '0);
      for (int c = 0; c < NUM_CHANNELS; c++)
      begin
         apb_read(reg_addr(ch_idx_t'(c), OFS_COUNT_IRQ), rdata, err);
         check_reg("COUNT_IRQ after reset", rdata, '0);     // Length and enable cleared
      end
      apb_read(12'h010, rdata, err);                         // Hole in channel 0 window
      check_flag("o_pslverr hole", err, 1'b1);
      check_reg("o_prdata hole", rdata, '0);
      apb_read(12'h104, rdata, err);                         // Past STATUS
      check_flag("o_pslverr unmapped", err, 1'b1);
      for (int b = 0; b < NUM_BATCHES; b++)
         run_batch(b);
      if (error_count == 0)
      begin
         $display("Simulation completed successfully");
         $finish;
      end
      else
      begin
         $display("Simulation failed");
         $fatal(1, "errors were found");
      end
   end

endmodule

// File: files.f
common/dma_rd_pkg.sv
common/apb_regs_pkg.sv
common/rd_req_if.sv
hw/apb_channel_regs.sv
hw/request_count.sv
hw/rr_mux.sv
hw/dma_read_req_top.sv
verif/tb_dma_read_req.sv

// File: Makefile
# Verilator build for the read request block testbench
# Override any variable from the command line, e.g. make run TOP=...

VERILATOR ?= verilator
TOP       ?= tb_dma_read_req
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation is the pass or fail result
run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
